// File: design/fp_format_pkg.sv
package fp_format_pkg;

    // IEEE 754 single precision layout
    localparam int EXP_W = 8;
    localparam int MAN_W = 23;
    localparam int SIG_W = MAN_W + 1;           // mantissa with the hidden one

    // all-ones exponent, taken as infinity whatever the mantissa holds
    localparam logic [EXP_W-1:0] EXP_MAX = '1;

    typedef struct packed {
        logic             sign;
        logic [EXP_W-1:0] exp;
        logic [MAN_W-1:0] man;
    } fp_fields_t;

    // one word seen either as a bus value or as its fields
    typedef union packed {
        logic [EXP_W+MAN_W:0] raw;
        fp_fields_t           f;
    } fp_word_u;

    typedef enum logic [1:0] {
        class_zero,                             // zero or flushed subnormal
        class_norm,
        class_inf
    } op_class_e;

endpackage

// File: design/adder_ctrl_pkg.sv
package adder_ctrl_pkg;

    // four-phase handshake tracking, same encoding on both sides
    typedef enum logic [1:0] {
        hs_idle,                                // no transfer open
        hs_active,                              // own strobe high, waiting for the far side
        hs_release                              // own strobe dropped, closing the transfer
    } hs_phase_e;

endpackage

// File: design/fp_operand_in.sv
`timescale 1ns/10ps

module fp_operand_in (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_req,
    input  fp_format_pkg::fp_word_u         i_fp1,
    input  fp_format_pkg::fp_word_u         i_fp2,
    input  logic                            i_take,
    output logic                            o_ack,
    output logic                            o_valid,
    output logic                            o_sign1,
    output logic                            o_sign2,
    output logic [fp_format_pkg::EXP_W-1:0] o_exp1,
    output logic [fp_format_pkg::EXP_W-1:0] o_exp2,
    output logic [fp_format_pkg::SIG_W-1:0] o_sig1,
    output logic [fp_format_pkg::SIG_W-1:0] o_sig2,
    output fp_format_pkg::op_class_e        o_class1,
    output fp_format_pkg::op_class_e        o_class2
);
    import fp_format_pkg::*;
    import adder_ctrl_pkg::*;

    hs_phase_e phase;
    logic      capture;

    // subnormals have exponent zero, so they land in class_zero
    function automatic op_class_e classify(input logic [EXP_W-1:0] e);
        op_class_e c;
        if (e == '0) begin
            c = class_zero;
        end else if (e == EXP_MAX) begin
            c = class_inf;
        end else begin
            c = class_norm;
        end
        return c;
    endfunction

    // register free now or emptied by stage 2 on this edge
    assign capture = (phase == hs_idle) && i_req && (!o_valid || i_take);
    assign o_ack   = (phase == hs_active);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            phase <= hs_idle;
        end else begin
            case (phase)
                hs_idle:   if (capture) phase <= hs_active;
                hs_active: if (!i_req) phase <= hs_release;    // ack drops here
                default:   phase <= hs_idle;                   // one low cycle before next req
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else if (capture) begin
            o_valid <= 1'b1;
        end else if (i_take) begin
            o_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (capture) begin
            o_sign1  <= i_fp1.f.sign;
            o_exp1   <= i_fp1.f.exp;
            o_sig1   <= {1'b1, i_fp1.f.man};          // hidden one, ignored unless normal
            o_class1 <= classify(i_fp1.f.exp);
            o_sign2  <= i_fp2.f.sign;
            o_exp2   <= i_fp2.f.exp;
            o_sig2   <= {1'b1, i_fp2.f.man};
            o_class2 <= classify(i_fp2.f.exp);
        end
    end

endmodule

// File: design/fp_align_add.sv
`timescale 1ns/10ps

module fp_align_add (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_valid,
    input  logic                            i_take_next,
    input  logic                            i_sign1,
    input  logic                            i_sign2,
    input  logic [fp_format_pkg::EXP_W-1:0] i_exp1,
    input  logic [fp_format_pkg::EXP_W-1:0] i_exp2,
    input  logic [fp_format_pkg::SIG_W-1:0] i_sig1,
    input  logic [fp_format_pkg::SIG_W-1:0] i_sig2,
    input  fp_format_pkg::op_class_e        i_class1,
    input  fp_format_pkg::op_class_e        i_class2,
    output logic                            o_take,
    output logic                            o_valid,
    output logic                            o_sign,
    output logic [fp_format_pkg::EXP_W-1:0] o_exp,
    output logic [fp_format_pkg::SIG_W:0]   o_sum,
    output fp_format_pkg::op_class_e        o_class
);
    import fp_format_pkg::*;

    logic             swap;
    logic             sign_big;
    logic             sign_small;
    logic [EXP_W-1:0] exp_big;
    logic [EXP_W-1:0] exp_small;
    logic [SIG_W-1:0] sig_big;
    logic [SIG_W-1:0] sig_small;
    logic [SIG_W-1:0] sig_aligned;
    logic [SIG_W:0]   mag_sum;

    logic             sign_c;
    logic [EXP_W-1:0] exp_c;
    logic [SIG_W:0]   sum_c;
    op_class_e        class_c;

    always_comb begin
        swap = (i_exp2 > i_exp1) || ((i_exp2 == i_exp1) && (i_sig2 > i_sig1));
        if (swap) begin
            sign_big   = i_sign2;
            exp_big    = i_exp2;
            sig_big    = i_sig2;
            sign_small = i_sign1;
            exp_small  = i_exp1;
            sig_small  = i_sig1;
        end else begin
            sign_big   = i_sign1;
            exp_big    = i_exp1;
            sig_big    = i_sig1;
            sign_small = i_sign2;
            exp_small  = i_exp2;
            sig_small  = i_sig2;
        end
        sig_aligned = sig_small >> (exp_big - exp_small);   // shifted-out bits are dropped
        if (sign_big == sign_small) begin
            mag_sum = {1'b0, sig_big} + {1'b0, sig_aligned};
        end else begin
            mag_sum = {1'b0, sig_big} - {1'b0, sig_aligned}; // never negative after ordering
        end
    end

    always_comb begin
        if ((i_class1 == class_inf) || (i_class2 == class_inf)) begin
            sign_c  = 1'b0;
            exp_c   = EXP_MAX;
            sum_c   = '0;
            class_c = class_inf;
        end else if ((i_class1 == class_zero) && (i_class2 == class_zero)) begin
            sign_c  = 1'b0;
            exp_c   = '0;
            sum_c   = '0;
            class_c = class_zero;
        end else if (i_class1 == class_zero) begin
            sign_c  = i_sign2;                              // pass operand 2 as is
            exp_c   = i_exp2;
            sum_c   = {1'b0, i_sig2};
            class_c = class_norm;
        end else if (i_class2 == class_zero) begin
            sign_c  = i_sign1;
            exp_c   = i_exp1;
            sum_c   = {1'b0, i_sig1};
            class_c = class_norm;
        end else begin
            sign_c  = sign_big;
            exp_c   = exp_big;
            sum_c   = mag_sum;
            class_c = class_norm;
        end
    end

    assign o_take = i_valid && (!o_valid || i_take_next);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else if (o_take) begin
            o_valid <= 1'b1;
        end else if (i_take_next) begin
            o_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_take) begin
            o_sign  <= sign_c;
            o_exp   <= exp_c;
            o_sum   <= sum_c;
            o_class <= class_c;
        end
    end

endmodule

// File: design/fp_normalize_out.sv
`timescale 1ns/10ps

module fp_normalize_out (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_valid,
    input  logic                            i_ack,
    input  logic                            i_sign,
    input  logic [fp_format_pkg::EXP_W-1:0] i_exp,
    input  logic [fp_format_pkg::SIG_W:0]   i_sum,
    input  fp_format_pkg::op_class_e        i_class,
    output logic                            o_take,
    output logic                            o_req,
    output fp_format_pkg::fp_word_u         o_fp
);
    import fp_format_pkg::*;
    import adder_ctrl_pkg::*;

    localparam int LZ_W = $clog2(SIG_W);

    hs_phase_e        phase;
    logic             can_load;
    logic [LZ_W-1:0]  lead_zeros;
    logic [EXP_W:0]   exp_inc;
    logic [SIG_W-1:0] norm_sig;
    fp_word_u         res_w;
    fp_word_u         word_q;

    // distance of the leading one from the top significand bit
    always_comb begin
        lead_zeros = '0;
        for (int i = 0; i < SIG_W; i++) begin
            if (i_sum[i]) begin
                lead_zeros = LZ_W'(SIG_W - 1 - i);
            end
        end
    end

    assign exp_inc  = {1'b0, i_exp} + (EXP_W+1)'(1);
    assign norm_sig = i_sum[SIG_W-1:0] << lead_zeros;

    always_comb begin
        res_w.raw = '0;                                     // +0 unless set below
        if (i_class == class_inf) begin
            res_w.f.exp = EXP_MAX;
        end else if ((i_class == class_zero) || (i_sum == '0)) begin
            res_w.raw = '0;                                 // cancellation gives +0
        end else if (i_sum[SIG_W]) begin
            res_w.f.sign = i_sign;
            if (exp_inc >= {1'b0, EXP_MAX}) begin
                res_w.f.exp = EXP_MAX;                      // signed infinity
            end else begin
                res_w.f.exp = exp_inc[EXP_W-1:0];
                res_w.f.man = i_sum[SIG_W-1:1];             // lsb truncated
            end
        end else if (i_exp > EXP_W'(lead_zeros)) begin
            res_w.f.sign = i_sign;
            res_w.f.exp  = i_exp - EXP_W'(lead_zeros);
            res_w.f.man  = norm_sig[MAN_W-1:0];
        end
        // exponent at or below zero falls through as +0
    end

    // free when empty, or once the last transfer has seen ack low
    assign can_load = (phase == hs_idle) || ((phase == hs_release) && !i_ack);
    assign o_take   = i_valid && can_load;
    assign o_req    = (phase == hs_active);
    assign o_fp     = word_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            phase <= hs_idle;
        end else if (o_take) begin
            phase <= hs_active;
        end else begin
            case (phase)
                hs_active:  if (i_ack) phase <= hs_release;
                hs_release: if (!i_ack) phase <= hs_idle;
                default:    phase <= hs_idle;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_take) begin
            word_q <= res_w;                                // held for the whole req phase
        end
    end

endmodule

// File: design/fp_adder_top.sv
`timescale 1ns/10ps

module fp_adder_top (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_req,
    input  fp_format_pkg::fp_word_u i_fp1,
    input  fp_format_pkg::fp_word_u i_fp2,
    output logic                    o_ack,
    output logic                    o_req,
    output fp_format_pkg::fp_word_u o_fp,
    input  logic                    i_ack
);
    import fp_format_pkg::*;

    logic             valid1;
    logic             take1;
    logic             sign1;
    logic             sign2;
    logic [EXP_W-1:0] exp1;
    logic [EXP_W-1:0] exp2;
    logic [SIG_W-1:0] sig1;
    logic [SIG_W-1:0] sig2;
    op_class_e        class1;
    op_class_e        class2;

    logic             valid2;
    logic             take2;
    logic             sum_sign;
    logic [EXP_W-1:0] sum_exp;
    logic [SIG_W:0]   sum_sig;
    op_class_e        sum_class;

    fp_operand_in operand_in_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_req    (i_req),
        .i_fp1    (i_fp1),
        .i_fp2    (i_fp2),
        .i_take   (take1),
        .o_ack    (o_ack),
        .o_valid  (valid1),
        .o_sign1  (sign1),
        .o_sign2  (sign2),
        .o_exp1   (exp1),
        .o_exp2   (exp2),
        .o_sig1   (sig1),
        .o_sig2   (sig2),
        .o_class1 (class1),
        .o_class2 (class2)
    );

    fp_align_add align_add_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (valid1),
        .i_take_next (take2),
        .i_sign1     (sign1),
        .i_sign2     (sign2),
        .i_exp1      (exp1),
        .i_exp2      (exp2),
        .i_sig1      (sig1),
        .i_sig2      (sig2),
        .i_class1    (class1),
        .i_class2    (class2),
        .o_take      (take1),
        .o_valid     (valid2),
        .o_sign      (sum_sign),
        .o_exp       (sum_exp),
        .o_sum       (sum_sig),
        .o_class     (sum_class)
    );

    fp_normalize_out normalize_out_i (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (valid2),
        .i_ack   (i_ack),
        .i_sign  (sum_sign),
        .i_exp   (sum_exp),
        .i_sum   (sum_sig),
        .i_class (sum_class),
        .o_take  (take2),
        .o_req   (o_req),
        .o_fp    (o_fp)
    );

endmodule

// File: tests/fp_adder_props.sv
`timescale 1ns/10ps

module fp_adder_props (
    input logic                    i_clk,
    input logic                    i_rst,
    input logic                    i_req,
    input logic                    i_ack,
    input logic                    i_dut_ack,
    input logic                    i_dut_req,
    input fp_format_pkg::fp_word_u i_dut_fp
);

    // result side holds its word until the far side acknowledges
    req_held_until_ack: assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_dut_req && !i_ack |=> i_dut_req && $stable(i_dut_fp)
    ) else $error("o_req dropped or o_fp changed before i_ack");

    ack_needs_req: assert property (
        @(posedge i_clk) disable iff (i_rst)
        $rose(i_dut_ack) |-> i_req
    ) else $error("o_ack rose while i_req was low");

    // ack as seen on the edge that raised o_req
    no_req_during_ack: assert property (
        @(posedge i_clk) disable iff (i_rst)
        $rose(i_dut_req) |-> !$past(i_ack)
    ) else $error("o_req rose again while i_ack was still high");

    quiet_after_reset: assert property (
        @(posedge i_clk)
        i_rst |=> !i_dut_ack && !i_dut_req
    ) else $error("o_ack or o_req high in the cycle after reset");

endmodule

bind fp_adder_top fp_adder_props props_i (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_req     (i_req),
    .i_ack     (i_ack),
    .i_dut_ack (o_ack),
    .i_dut_req (o_req),
    .i_dut_fp  (o_fp)
);

// File: tests/fp_adder_tb.sv
`timescale 1ns/10ps

module fp_adder_tb;

    localparam string CASE_FILE = "tests/fp_add_cases.txt";

    logic        clk = 1'b0;
    logic        rst;
    logic        in_req;
    logic [31:0] in_fp1;
    logic [31:0] in_fp2;
    logic        in_ack;
    logic        out_ack;
    logic        out_req;
    logic [31:0] out_fp;

    logic [31:0] fp1_q[$];
    logic [31:0] fp2_q[$];
    logic [31:0] expect_q[$];              // popped in result order

    integer      seed    = 18490;
    int          n_cases = 0;
    int          n_done  = 0;
    int          cycles  = 0;
    int          limit   = 0;

    fp_adder_top dut_i (
        .i_clk (clk),
        .i_rst (rst),
        .i_req (in_req),
        .i_fp1 (in_fp1),
        .i_fp2 (in_fp2),
        .o_ack (out_ack),
        .o_req (out_req),
        .o_fp  (out_fp),
        .i_ack (in_ack)
    );

    always #4 clk = ~clk;

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    // lines that do not parse as three hex words are comments
    task automatic load_cases();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sum;
        fd = $fopen(CASE_FILE, "r");
        assert (fd != 0) else stop_with_error("cannot open the case file");
        while ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%h %h %h", a, b, sum);
            if (fields == 3) begin
                fp1_q.push_back(a);
                fp2_q.push_back(b);
                expect_q.push_back(sum);
            end
        end
        $fclose(fd);
        n_cases = fp1_q.size();
        assert (n_cases > 0) else stop_with_error("the case file holds no cases");
    endtask

    // called on a rising edge, returns on the edge that sees o_ack low again
    task automatic send_operands(input logic [31:0] a, input logic [31:0] b);
        in_req <= 1'b1;
        in_fp1 <= a;
        in_fp2 <= b;
        do @(posedge clk); while (!out_ack);
        in_req <= 1'b0;
        do @(posedge clk); while (out_ack);
    endtask

    task automatic check_result(input logic [31:0] got);
        logic [31:0] want;
        assert (expect_q.size() != 0)
            else stop_with_error("a result arrived with no case left to match it");
        want = expect_q.pop_front();
        n_done++;
        assert (got === want) else begin
            stop_with_error($sformatf("ERR %0d ns: o_fp expected %08h actual %08h",
                                      $time, want, got));
        end
    endtask

    initial begin : main_flow
        rst    <= 1'b1;
        in_req <= 1'b0;
        in_fp1 <= '0;
        in_fp2 <= '0;
        load_cases();
        limit = 20 * n_cases + 50;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        foreach (fp1_q[k]) begin
            send_operands(fp1_q[k], fp2_q[k]);          // back to back, no idle gap
        end
        while (n_done < n_cases) begin
            @(posedge clk);
        end
        $display("RESULT: PASS");
        $finish;
    end

    // answers each o_req after 0 to 5 cycles
    initial begin : ack_responder
        int delay;
        in_ack <= 1'b0;
        forever begin
            @(posedge clk);
            if (!rst && out_req) begin
                check_result(out_fp);                   // o_fp is held while o_req is high
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) @(posedge clk);
                in_ack <= 1'b1;
                do @(posedge clk); while (out_req);
                in_ack <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            stop_with_error("timeout: results stopped arriving before all cases were checked");
        end
    end

endmodule

// File: tests/fp_add_cases.txt
# fp1 fp2 expected, all single-precision words in hex
# text after a hash is a note and is not read
3F800000 3F800000 40000000  # 1 + 1 carry
3F800000 40000000 40400000  # 1 + 2
3FC00000 3FC00000 40400000  # 1.5 + 1.5 carry
3FFFFFFF 3FFFFFFF 407FFFFF  # carry drops the lsb
3F800000 34400000 3F800001  # aligned bits truncated
3F800001 3F800000 40000000  # carry truncates lsb
3F800000 30000000 3F800000  # shift past the significand
42C80000 3F000000 42C90000  # 100 + 0.5
BF800000 C0000000 C0400000  # -1 + -2
40400000 BF800000 40000000  # 3 - 1
3F800000 C0400000 C0000000  # 1 - 3 takes the larger sign
3F800000 BF400000 3E800000  # 1 - 0.75 left shift by 2
40A00000 C0F00000 C0200000  # 5 - 7.5
3F800000 BF7FFFFF 34000000  # deep cancellation
40490FDB C0490FDB 00000000  # exact cancellation
BF800000 3F800000 00000000  # exact cancellation, negative first
01800000 80C00000 01200000  # small result stays normal
00000000 C0490FDB C0490FDB  # zero passes the other
41200000 80000000 41200000  # negative zero passes the other
00000001 3F800000 3F800000  # subnormal flushed
3F123456 807FFFFF 3F123456  # negative subnormal flushed
80000000 80000000 00000000  # two zeros give +0
00400000 00400000 00000000  # two subnormals give +0
7F800000 3F800000 7F800000  # +inf operand
FF800000 3F800000 7F800000  # -inf operand gives +inf
7FC00000 00000000 7F800000  # nan code taken as inf
FF800000 7F800000 7F800000  # inf plus inf
7F7FFFFF 7F7FFFFF 7F800000  # exponent overflow
FF000000 FF000000 FF800000  # negative overflow
00C00000 80800000 00000000  # cancellation below smallest exponent

// File: sim.f
design/fp_format_pkg.sv
design/adder_ctrl_pkg.sv
design/fp_operand_in.sv
design/fp_align_add.sv
design/fp_normalize_out.sv
design/fp_adder_top.sv
tests/fp_adder_props.sv
tests/fp_adder_tb.sv

// File: Makefile
# Verilator build and run of the adder testbench
# override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= fp_adder_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# a $fatal in the testbench makes the binary exit non-zero
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
